//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // major opcodes, instruction bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f
    } opcode_e;

    // SPECIAL function codes, instruction bits 5:0
    typedef enum logic [5:0] {
        FN_JR      = 6'h08,
        FN_SYSCALL = 6'h0c,
        FN_ADDU    = 6'h21,
        FN_SUBU    = 6'h23,
        FN_AND     = 6'h24,
        FN_OR      = 6'h25,
        FN_XOR     = 6'h26,
        FN_SLT     = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    // cause register encodings
    typedef enum logic [4:0] {
        EXC_ADEL = 5'd4,
        EXC_SYS  = 5'd8,
        EXC_RI   = 5'd10
    } exc_code_e;

    // {inst_valid, pc, ex, excode}
    localparam int PS_TO_FS_BUS_WD = 39;
    // {ex, excode, bd, inst, pc}
    localparam int FS_TO_DS_BUS_WD = 71;
    // {pc, ex, excode, bd, alu_op, src1, src2, dest, wen, is_syscall}
    localparam int DS_TO_ES_BUS_WD = 113;
    // {pc, ex, excode, bd, result, dest, wen}
    localparam int ES_TO_WS_BUS_WD = 77;

    localparam logic [31:0] RESET_PC   = 32'hbfc0_0000;
    localparam logic [31:0] EXC_VECTOR = 32'h0000_0380;

endpackage

`default_nettype wire

//--- pre_if_stage.sv
`timescale 1ns/1ns
`default_nettype none

module pre_if_stage import cpu_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       fs_allowin,
    input  logic                       br_taken,
    input  logic [31:0]                br_target,
    input  logic                       flush,
    output logic                       ps_to_fs_valid,
    output logic [PS_TO_FS_BUS_WD-1:0] ps_to_fs_bus,
    output logic                       inst_req,
    output logic [31:0]                inst_addr
);

    logic        ps_valid;
    logic [31:0] pc;
    logic        br_pending;
    logic [31:0] br_pending_target;
    logic [31:0] fetch_pc;
    logic        ps_go;
    logic        adel;

    // branch resolved while fetch was stalled is held until it goes out
    assign fetch_pc = br_taken   ? br_target :
                      br_pending ? br_pending_target : pc;

    assign ps_go = ps_valid && fs_allowin && !flush;
    assign adel  = fetch_pc[1:0] != 2'b00;

    always_ff @(posedge clk) begin
        if (reset) begin
            ps_valid   <= 1'b0;
            pc         <= RESET_PC;
            br_pending <= 1'b0;
        end else begin
            ps_valid <= 1'b1;
            if (flush) begin
                pc         <= EXC_VECTOR;
                br_pending <= 1'b0;
            end else if (ps_go) begin
                pc         <= fetch_pc + 32'd4;
                br_pending <= 1'b0;
            end else if (br_taken) begin
                br_pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (br_taken) begin
            br_pending_target <= br_target;
        end
    end

    assign ps_to_fs_valid = ps_valid;
    // misaligned pc travels with ADEL and no instruction behind it
    assign ps_to_fs_bus   = {!adel, fetch_pc, adel, adel ? EXC_ADEL : 5'd0};
    assign inst_req       = ps_go;
    assign inst_addr      = fetch_pc;

endmodule

`default_nettype wire

//--- if_stage.sv
`timescale 1ns/1ns
`default_nettype none

module if_stage import cpu_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    output logic                       fs_allowin,
    input  logic                       ds_allowin,
    input  logic [PS_TO_FS_BUS_WD-1:0] ps_to_fs_bus,
    input  logic                       ps_to_fs_valid,
    input  logic                       fs_bd,
    output logic                       fs_to_ds_valid,
    output logic [FS_TO_DS_BUS_WD-1:0] fs_to_ds_bus,
    input  logic                       flush,
    input  logic                       icache_busy,
    input  logic [31:0]                inst_rdata
);

    logic                       fs_valid;
    logic                       fs_ready_go;
    logic [PS_TO_FS_BUS_WD-1:0] ps_to_fs_bus_r;
    logic                       fs_inst_valid;
    logic [31:0]                fs_pc;
    logic                       fs_ex;
    logic [4:0]                 fs_excode;
    logic [31:0]                fs_inst;
    logic                       fs_bd_r;

    assign {fs_inst_valid, fs_pc, fs_ex, fs_excode} = ps_to_fs_bus_r;

    assign fs_ready_go    = !icache_busy;
    assign fs_allowin     = !fs_valid || (fs_ready_go && ds_allowin);
    assign fs_to_ds_valid = fs_valid && fs_ready_go;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            fs_valid <= 1'b0;
        end else if (fs_allowin) begin
            fs_valid <= ps_to_fs_valid;
        end
    end

    // cleared bus reads as an all-zero no-op
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ps_to_fs_bus_r <= '0;
        end else if (ps_to_fs_valid && fs_allowin) begin
            ps_to_fs_bus_r <= ps_to_fs_bus;
        end
    end

    // branch may leave decode while its delay slot still waits here
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            fs_bd_r <= 1'b0;
        end else if (fs_to_ds_valid && ds_allowin) begin
            fs_bd_r <= 1'b0;
        end else if (fs_valid && fs_bd) begin
            fs_bd_r <= 1'b1;
        end
    end

    assign fs_inst      = fs_inst_valid ? inst_rdata : 32'd0;
    assign fs_to_ds_bus = {fs_ex, fs_excode, fs_bd || fs_bd_r, fs_inst, fs_pc};

endmodule

`default_nettype wire

//--- id_stage.sv
`timescale 1ns/1ns
`default_nettype none

module id_stage import cpu_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    output logic                       ds_allowin,
    input  logic                       es_allowin,
    input  logic                       fs_to_ds_valid,
    input  logic [FS_TO_DS_BUS_WD-1:0] fs_to_ds_bus,
    output logic                       ds_to_es_valid,
    output logic [DS_TO_ES_BUS_WD-1:0] ds_to_es_bus,
    output logic                       fs_bd,
    output logic                       br_taken,
    output logic [31:0]                br_target,
    input  logic                       es_dest_valid,
    input  logic [4:0]                 es_dest,
    input  logic                       ws_dest_valid,
    input  logic [4:0]                 ws_dest,
    input  logic                       rf_we,
    input  logic [4:0]                 rf_waddr,
    input  logic [31:0]                rf_wdata,
    input  logic                       flush
);

    logic                       ds_valid;
    logic                       ds_ready_go;
    logic [FS_TO_DS_BUS_WD-1:0] fs_to_ds_bus_r;
    logic                       fs_ex;
    logic [4:0]                 fs_excode;
    logic                       ds_bd;
    logic [31:0]                ds_inst;
    logic [31:0]                ds_pc;
    opcode_e                    op;
    funct_e                     funct;
    logic [4:0]                 rs;
    logic [4:0]                 rt;
    logic [4:0]                 rd;
    logic [15:0]                imm;
    logic [31:0]                rf [32];
    logic [31:0]                rs_value;
    logic [31:0]                rt_value;
    alu_op_e                    alu_op;
    logic [31:0]                src2;
    logic [4:0]                 dest;
    logic                       wen;
    logic                       use_rs;
    logic                       use_rt;
    logic                       is_br;
    logic                       br_cond;
    logic                       is_syscall;
    logic                       ri;
    logic                       ds_ex;
    logic                       hazard;

    // register 0 reads zero, a write in this cycle is seen by the read
    function automatic logic [31:0] rf_read(input logic [4:0] addr);
        if (addr == 5'd0) return 32'd0;
        if (rf_we && rf_waddr == addr) return rf_wdata;
        return rf[addr];
    endfunction

    assign {fs_ex, fs_excode, ds_bd, ds_inst, ds_pc} = fs_to_ds_bus_r;
    assign op    = opcode_e'(ds_inst[31:26]);
    assign funct = funct_e'(ds_inst[5:0]);
    assign rs    = ds_inst[25:21];
    assign rt    = ds_inst[20:16];
    assign rd    = ds_inst[15:11];
    assign imm   = ds_inst[15:0];

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            fs_to_ds_bus_r <= fs_to_ds_bus;
        end
        if (rf_we && rf_waddr != 5'd0) begin
            rf[rf_waddr] <= rf_wdata;
        end
    end

    always_comb begin
        rs_value = rf_read(rs);
        rt_value = rf_read(rt);
    end

    always_comb begin
        alu_op     = ALU_ADD;
        src2       = rt_value;
        dest       = rd;
        wen        = 1'b0;
        use_rs     = 1'b1;
        use_rt     = 1'b0;
        is_br      = 1'b0;
        br_cond    = 1'b0;
        is_syscall = 1'b0;
        ri         = 1'b0;
        // targets relative to the delay slot pc
        br_target  = ds_pc + 32'd4 + {{14{imm[15]}}, imm, 2'b00};
        case (op)
            OP_SPECIAL: begin
                use_rt = 1'b1;
                wen    = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_JR: begin
                        wen       = 1'b0;
                        use_rt    = 1'b0;
                        is_br     = 1'b1;
                        br_cond   = 1'b1;
                        br_target = rs_value;
                    end
                    FN_SYSCALL: begin
                        wen        = 1'b0;
                        use_rs     = 1'b0;
                        use_rt     = 1'b0;
                        is_syscall = 1'b1;
                    end
                    default: begin
                        wen = 1'b0;
                        ri  = 1'b1;
                    end
                endcase
            end
            OP_BEQ, OP_BNE: begin
                use_rt  = 1'b1;
                is_br   = 1'b1;
                br_cond = (rs_value == rt_value) == (op == OP_BEQ);
            end
            OP_ADDIU: begin
                src2 = {{16{imm[15]}}, imm};
                dest = rt;
                wen  = 1'b1;
            end
            OP_ORI, OP_LUI: begin
                alu_op = (op == OP_ORI) ? ALU_OR : ALU_LUI;
                use_rs = (op == OP_ORI);
                src2   = {16'd0, imm};
                dest   = rt;
                wen    = 1'b1;
            end
            default: ri = 1'b1;
        endcase
    end

    // interlock on any source still owned by ex or wb
    assign hazard = (use_rs && rs != 5'd0 &&
                        ((es_dest_valid && es_dest == rs) || (ws_dest_valid && ws_dest == rs))) ||
                    (use_rt && rt != 5'd0 &&
                        ((es_dest_valid && es_dest == rt) || (ws_dest_valid && ws_dest == rt)));

    assign ds_ready_go    = !hazard;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    // an earlier fetch exception keeps its own code
    assign ds_ex = fs_ex || ri;

    assign ds_to_es_bus = {ds_pc, ds_ex, fs_ex ? fs_excode : EXC_RI, ds_bd, alu_op,
                           rs_value, src2, dest, wen && !ds_ex, is_syscall};

    assign fs_bd    = ds_valid && is_br;
    assign br_taken = ds_valid && ds_ready_go && es_allowin && is_br && br_cond;

endmodule

`default_nettype wire

//--- ex_stage.sv
`timescale 1ns/1ns
`default_nettype none

module ex_stage import cpu_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    output logic                       es_allowin,
    input  logic                       ws_allowin,
    input  logic                       ds_to_es_valid,
    input  logic [DS_TO_ES_BUS_WD-1:0] ds_to_es_bus,
    output logic                       es_to_ws_valid,
    output logic [ES_TO_WS_BUS_WD-1:0] es_to_ws_bus,
    output logic                       es_dest_valid,
    output logic [4:0]                 es_dest,
    input  logic                       flush
);

    logic                       es_valid;
    logic                       es_ready_go;
    logic [DS_TO_ES_BUS_WD-1:0] ds_to_es_bus_r;
    logic [31:0]                es_pc;
    logic                       ds_ex;
    logic [4:0]                 ds_excode;
    logic                       es_bd;
    logic [2:0]                 es_alu_op;
    logic [31:0]                es_src1;
    logic [31:0]                es_src2;
    logic                       es_wen;
    logic                       es_is_syscall;
    logic                       es_ex;
    logic [31:0]                alu_result;

    assign {es_pc, ds_ex, ds_excode, es_bd, es_alu_op, es_src1, es_src2,
            es_dest, es_wen, es_is_syscall} = ds_to_es_bus_r;

    assign es_ready_go    = 1'b1;
    assign es_allowin     = !es_valid || (es_ready_go && ws_allowin);
    assign es_to_ws_valid = es_valid && es_ready_go;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_to_es_valid && es_allowin) begin
            ds_to_es_bus_r <= ds_to_es_bus;
        end
    end

    always_comb begin
        case (alu_op_e'(es_alu_op))
            ALU_SUB: alu_result = es_src1 - es_src2;
            ALU_AND: alu_result = es_src1 & es_src2;
            ALU_OR:  alu_result = es_src1 | es_src2;
            ALU_XOR: alu_result = es_src1 ^ es_src2;
            ALU_SLT: alu_result = {31'd0, $signed(es_src1) < $signed(es_src2)};
            ALU_LUI: alu_result = {es_src2[15:0], 16'd0};
            default: alu_result = es_src1 + es_src2;
        endcase
    end

    assign es_ex = ds_ex || es_is_syscall;

    assign es_to_ws_bus = {es_pc, es_ex, ds_ex ? ds_excode : EXC_SYS, es_bd,
                           alu_result, es_dest, es_wen && !es_ex};

    assign es_dest_valid = es_valid && es_wen && !es_ex;

endmodule

`default_nettype wire

//--- wb_stage.sv
`timescale 1ns/1ns
`default_nettype none

module wb_stage import cpu_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    output logic                       ws_allowin,
    input  logic                       es_to_ws_valid,
    input  logic [ES_TO_WS_BUS_WD-1:0] es_to_ws_bus,
    output logic                       rf_we,
    output logic [4:0]                 rf_waddr,
    output logic [31:0]                rf_wdata,
    output logic                       ws_dest_valid,
    output logic [4:0]                 ws_dest,
    output logic                       flush,
    output logic                       retire_valid,
    output logic [31:0]                retire_pc,
    output logic                       retire_wen,
    output logic [4:0]                 retire_waddr,
    output logic [31:0]                retire_wdata,
    output logic                       exc_valid,
    output exc_code_e                  exc_code,
    output logic [31:0]                exc_epc,
    output logic                       exc_bd
);

    logic                       ws_valid;
    logic                       ws_ready_go;
    logic [ES_TO_WS_BUS_WD-1:0] es_to_ws_bus_r;
    logic [31:0]                ws_pc;
    logic                       ws_ex;
    logic [4:0]                 ws_excode;
    logic                       ws_bd;
    logic [31:0]                ws_result;
    logic                       ws_wen;

    assign {ws_pc, ws_ex, ws_excode, ws_bd, ws_result, ws_dest, ws_wen} = es_to_ws_bus_r;

    // write-back never stalls
    assign ws_ready_go = 1'b1;
    assign ws_allowin  = !ws_valid || ws_ready_go;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= es_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ws_valid && ws_allowin) begin
            es_to_ws_bus_r <= es_to_ws_bus;
        end
    end

    assign retire_valid  = ws_valid && !ws_ex;
    assign retire_pc     = ws_pc;
    assign retire_wen    = ws_wen;
    assign retire_waddr  = ws_dest;
    assign retire_wdata  = ws_result;

    assign rf_we         = retire_valid && ws_wen;
    assign rf_waddr      = ws_dest;
    assign rf_wdata      = ws_result;
    assign ws_dest_valid = ws_valid && ws_wen;

    // exception commits here and empties the pipe
    assign flush     = ws_valid && ws_ex;
    assign exc_valid = flush;
    assign exc_code  = exc_code_e'(ws_excode);
    assign exc_epc   = ws_bd ? ws_pc - 32'd4 : ws_pc;
    assign exc_bd    = ws_bd;

endmodule

`default_nettype wire

//--- cpu_core.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_core import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    output logic        inst_req,
    output logic [31:0] inst_addr,
    input  logic [31:0] inst_rdata,
    input  logic        icache_busy,
    output logic        retire_valid,
    output logic [31:0] retire_pc,
    output logic        retire_wen,
    output logic [4:0]  retire_waddr,
    output logic [31:0] retire_wdata,
    output logic        exc_valid,
    output exc_code_e   exc_code,
    output logic [31:0] exc_epc,
    output logic        exc_bd
);

    logic                       fs_allowin;
    logic                       ds_allowin;
    logic                       es_allowin;
    logic                       ws_allowin;
    logic                       ps_to_fs_valid;
    logic [PS_TO_FS_BUS_WD-1:0] ps_to_fs_bus;
    logic                       fs_to_ds_valid;
    logic [FS_TO_DS_BUS_WD-1:0] fs_to_ds_bus;
    logic                       ds_to_es_valid;
    logic [DS_TO_ES_BUS_WD-1:0] ds_to_es_bus;
    logic                       es_to_ws_valid;
    logic [ES_TO_WS_BUS_WD-1:0] es_to_ws_bus;
    logic                       br_taken;
    logic [31:0]                br_target;
    logic                       fs_bd;
    logic                       es_dest_valid;
    logic [4:0]                 es_dest;
    logic                       ws_dest_valid;
    logic [4:0]                 ws_dest;
    logic                       rf_we;
    logic [4:0]                 rf_waddr;
    logic [31:0]                rf_wdata;
    logic                       flush;

    pre_if_stage u_pre_if (
        .clk, .reset, .fs_allowin, .br_taken, .br_target, .flush,
        .ps_to_fs_valid, .ps_to_fs_bus, .inst_req, .inst_addr
    );

    if_stage u_if (
        .clk, .reset, .fs_allowin, .ds_allowin, .ps_to_fs_bus, .ps_to_fs_valid,
        .fs_bd, .fs_to_ds_valid, .fs_to_ds_bus, .flush, .icache_busy, .inst_rdata
    );

    id_stage u_id (
        .clk, .reset, .ds_allowin, .es_allowin, .fs_to_ds_valid, .fs_to_ds_bus,
        .ds_to_es_valid, .ds_to_es_bus, .fs_bd, .br_taken, .br_target,
        .es_dest_valid, .es_dest, .ws_dest_valid, .ws_dest,
        .rf_we, .rf_waddr, .rf_wdata, .flush
    );

    ex_stage u_ex (
        .clk, .reset, .es_allowin, .ws_allowin, .ds_to_es_valid, .ds_to_es_bus,
        .es_to_ws_valid, .es_to_ws_bus, .es_dest_valid, .es_dest, .flush
    );

    wb_stage u_wb (
        .clk, .reset, .ws_allowin, .es_to_ws_valid, .es_to_ws_bus,
        .rf_we, .rf_waddr, .rf_wdata, .ws_dest_valid, .ws_dest, .flush,
        .retire_valid, .retire_pc, .retire_wen, .retire_waddr, .retire_wdata,
        .exc_valid, .exc_code, .exc_epc, .exc_bd
    );

endmodule

`default_nettype wire

//--- tb_cpu_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_core import cpu_pkg::*; ();

    localparam int REGION_WORDS  = 128;
    localparam int NUM_EVENTS    = 600;
    localparam int EVENT_TIMEOUT = 100;

    logic        clk;
    logic        reset;
    logic        inst_req;
    logic [31:0] inst_addr;
    logic [31:0] inst_rdata;
    logic        icache_busy;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic        retire_wen;
    logic [4:0]  retire_waddr;
    logic [31:0] retire_wdata;
    logic        exc_valid;
    exc_code_e   exc_code;
    logic [31:0] exc_epc;
    logic        exc_bd;

    logic [31:0] lfsr_state;
    logic [31:0] busy_bits;
    // region 0 sits at the reset pc, region 1 at the exception vector
    logic [31:0] prog [2][REGION_WORDS];
    // reference ISA state, npc models the delay slot
    logic [31:0] ref_pc;
    logic [31:0] ref_npc;
    logic        ref_bd;
    logic [31:0] ref_regs [32];
    logic [31:0] exp_pc;
    logic        exp_wen;
    logic [4:0]  exp_waddr;
    logic [31:0] exp_wdata;
    exc_code_e   exp_code;
    logic [31:0] exp_epc;
    logic        exp_bd;
    int          mismatch_count;
    int          order_errors;
    int          timeout_count;

    cpu_core dut_i (
        .clk, .reset, .inst_req, .inst_addr, .inst_rdata, .icache_busy,
        .retire_valid, .retire_pc, .retire_wen, .retire_waddr, .retire_wdata,
        .exc_valid, .exc_code, .exc_epc, .exc_bd
    );

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        int k;
        v = 32'd0;
        for (k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // unmapped words decode as reserved, pattern covers the whole word address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [29:0] word;
        logic [29:0] off_reset;
        logic [29:0] off_exc;
        word      = addr[31:2];
        off_reset = word - RESET_PC[31:2];
        off_exc   = word - EXC_VECTOR[31:2];
        if (off_reset < 30'(REGION_WORDS)) return prog[0][off_reset[6:0]];
        if (off_exc < 30'(REGION_WORDS)) return prog[1][off_exc[6:0]];
        return {6'h3f, word[25:0] ^ {word[29:26], 22'd0}};
    endfunction

    task automatic emit_alu(output logic [31:0] w);
        logic [31:0] bits;
        funct_e      fn;
        take_bits(12, bits);
        case (bits[11:9])
            3'd1: fn = FN_SUBU;
            3'd2: fn = FN_AND;
            3'd3: fn = FN_OR;
            3'd4: fn = FN_XOR;
            3'd5, 3'd6: fn = FN_SLT;
            default: fn = FN_ADDU;
        endcase
        w = {OP_SPECIAL, 2'b00, bits[8:6], 2'b00, bits[5:3], 2'b00, bits[2:0], 5'd0, fn};
    endtask

    // jr delay slots hold plain ALU ops, branch delay slots now and then a syscall
    task automatic build_region(input int r);
        logic [31:0] base;
        logic [31:0] sel;
        logic [31:0] bits;
        logic [31:0] target;
        logic [4:0]  x;
        opcode_e     op;
        int          i;
        base = (r != 0) ? EXC_VECTOR : RESET_PC;
        i = 0;
        if (r == 0) begin
            for (i = 0; i < 7; i++) begin
                take_bits(16, bits);
                prog[r][i] = {OP_ADDIU, 5'd0, 5'(i + 1), bits[15:0]};
            end
        end
        while (i < REGION_WORDS) begin
            take_bits(5, sel);
            if (i > REGION_WORDS - 4 || sel < 16 || sel >= 30) begin
                emit_alu(prog[r][i]);
                i = i + 1;
            end else if (sel < 22) begin
                take_bits(24, bits);
                case (bits[23:22])
                    2'd2: op = OP_ORI;
                    2'd3: op = OP_LUI;
                    default: op = OP_ADDIU;
                endcase
                prog[r][i] = {op, 2'b00, bits[21:19], 2'b00, bits[18:16], bits[15:0]};
                i = i + 1;
            end else if (sel < 26) begin
                take_bits(13, bits);
                op = bits[10] ? OP_BNE : OP_BEQ;
                x  = bits[3] ? {2'b00, bits[9:7]} : {2'b00, bits[6:4]};
                prog[r][i] = {op, 2'b00, bits[9:7], x, 16'(bits[2:0] + 1)};
                if (bits[12:11] == 2'b11) begin
                    prog[r][i + 1] = {OP_SPECIAL, 20'd0, FN_SYSCALL};
                end else begin
                    emit_alu(prog[r][i + 1]);
                end
                i = i + 2;
            end else if (sel < 28) begin
                // lui/ori build the target, then jr through it
                take_bits(8, bits);
                x = (bits[7:5] == 3'd0) ? 5'd7 : {2'b00, bits[7:5]};
                target = base + 32'((i + 4 + bits[4:2]) * 4);
                if (bits[1:0] == 2'b11) target = target + 32'd2;
                prog[r][i]     = {OP_LUI, 5'd0, x, target[31:16]};
                prog[r][i + 1] = {OP_ORI, x, x, target[15:0]};
                prog[r][i + 2] = {OP_SPECIAL, x, 15'd0, FN_JR};
                emit_alu(prog[r][i + 3]);
                i = i + 4;
            end else if (sel == 28) begin
                prog[r][i] = {OP_SPECIAL, 20'd0, FN_SYSCALL};
                i = i + 1;
            end else begin
                take_bits(26, bits);
                prog[r][i] = bits[0] ? {6'h3e, bits[25:0]} : {OP_SPECIAL, bits[25:6], 6'h00};
                i = i + 1;
            end
        end
    endtask

    // one ISA step, returns 1 for an exception and leaves the event in exp_*
    function automatic logic ref_step();
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] rs_v;
        logic [31:0] rt_v;
        logic [31:0] simm;
        logic [31:0] next_npc;
        logic        branch;
        logic        fault;
        pc        = ref_pc;
        inst      = mem_word(pc);
        rs_v      = ref_regs[inst[25:21]];
        rt_v      = ref_regs[inst[20:16]];
        simm      = {{16{inst[15]}}, inst[15:0]};
        next_npc  = ref_npc + 32'd4;
        branch    = 1'b0;
        fault     = 1'b0;
        exp_pc    = pc;
        exp_code  = EXC_RI;
        exp_wen   = 1'b0;
        exp_waddr = 5'd0;
        exp_wdata = 32'd0;
        if (pc[1:0] != 2'b00) begin
            fault    = 1'b1;
            exp_code = EXC_ADEL;
        end else begin
            case (inst[31:26])
                OP_SPECIAL: begin
                    exp_wen   = 1'b1;
                    exp_waddr = inst[15:11];
                    case (inst[5:0])
                        FN_ADDU: exp_wdata = rs_v + rt_v;
                        FN_SUBU: exp_wdata = rs_v - rt_v;
                        FN_AND:  exp_wdata = rs_v & rt_v;
                        FN_OR:   exp_wdata = rs_v | rt_v;
                        FN_XOR:  exp_wdata = rs_v ^ rt_v;
                        FN_SLT:  exp_wdata = {31'd0, $signed(rs_v) < $signed(rt_v)};
                        FN_JR: begin
                            exp_wen  = 1'b0;
                            branch   = 1'b1;
                            next_npc = rs_v;
                        end
                        FN_SYSCALL: begin
                            exp_wen  = 1'b0;
                            fault    = 1'b1;
                            exp_code = EXC_SYS;
                        end
                        default: begin
                            exp_wen = 1'b0;
                            fault   = 1'b1;
                        end
                    endcase
                end
                OP_BEQ: begin
                    branch = 1'b1;
                    if (rs_v == rt_v) next_npc = ref_npc + (simm << 2);
                end
                OP_BNE: begin
                    branch = 1'b1;
                    if (rs_v != rt_v) next_npc = ref_npc + (simm << 2);
                end
                OP_ADDIU: begin
                    exp_wen   = 1'b1;
                    exp_waddr = inst[20:16];
                    exp_wdata = rs_v + simm;
                end
                OP_ORI: begin
                    exp_wen   = 1'b1;
                    exp_waddr = inst[20:16];
                    exp_wdata = rs_v | {16'd0, inst[15:0]};
                end
                OP_LUI: begin
                    exp_wen   = 1'b1;
                    exp_waddr = inst[20:16];
                    exp_wdata = {inst[15:0], 16'd0};
                end
                default: fault = 1'b1;
            endcase
        end
        if (fault) begin
            exp_epc = ref_bd ? pc - 32'd4 : pc;
            exp_bd  = ref_bd;
            ref_pc  = EXC_VECTOR;
            ref_npc = EXC_VECTOR + 32'd4;
            ref_bd  = 1'b0;
        end else begin
            if (exp_wen && exp_waddr != 5'd0) ref_regs[exp_waddr] = exp_wdata;
            ref_pc  = ref_npc;
            ref_npc = next_npc;
            ref_bd  = branch;
        end
        return fault;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            $display("CHECK FAILED time %0t %s: got %h, expected %h", $time, name, got, want);
            mismatch_count++;
        end
    endtask

    task automatic check_retire(input logic [31:0] pc, input logic wen,
                                input logic [4:0] waddr, input logic [31:0] wdata);
        compare_value("retire_pc", pc, exp_pc);
        compare_value("retire_wen", 32'(wen), 32'(exp_wen));
        // address and data only mean something on a write
        if (exp_wen) begin
            compare_value("retire_waddr", 32'(waddr), 32'(exp_waddr));
            compare_value("retire_wdata", wdata, exp_wdata);
        end
    endtask

    task automatic check_exc(input exc_code_e code, input logic [31:0] epc, input logic bd);
        compare_value("exc_code", 32'(code), 32'(exp_code));
        compare_value("exc_epc", epc, exp_epc);
        compare_value("exc_bd", 32'(bd), 32'(exp_bd));
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin : stimulus
        int k;
        reset          = 1'b1;
        icache_busy    = 1'b0;
        inst_rdata     = 32'd0;
        busy_bits      = 32'd0;
        lfsr_state     = 32'h8a58840f;
        mismatch_count = 0;
        order_errors   = 0;
        timeout_count  = 0;
        build_region(0);
        build_region(1);
        ref_pc  = RESET_PC;
        ref_npc = RESET_PC + 32'd4;
        ref_bd  = 1'b0;
        for (k = 0; k < 32; k++) ref_regs[k] = 32'd0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

    // memory latches each request and holds the word until the next one
    always @(posedge clk) begin
        if (reset) begin
            icache_busy <= 1'b0;
        end else begin
            take_bits(2, busy_bits);
            icache_busy <= busy_bits[1:0] == 2'b00;
        end
        if (inst_req) begin
            inst_rdata <= mem_word(inst_addr);
        end
    end

    initial begin : compare
        int   waited;
        int   checked;
        logic fault;
        logic timed_out;
        waited = 0;
        @(negedge clk);
        while (reset && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (reset) begin
            $display("reset was never released");
            timeout_count++;
        end
        checked   = 0;
        timed_out = 1'b0;
        while (checked < NUM_EVENTS && !timed_out) begin
            waited = 0;
            @(negedge clk);
            while (!retire_valid && !exc_valid && waited < EVENT_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!retire_valid && !exc_valid) begin
                $display("no retirement or exception within %0d cycles after event %0d",
                         EVENT_TIMEOUT, checked);
                timeout_count++;
                timed_out = 1'b1;
            end else begin
                fault = ref_step();
                if (exc_valid !== fault) begin
                    $display("event %0d at %0t: core reported %s, reference expected %s at pc %h",
                             checked, $time, exc_valid ? "an exception" : "a retirement",
                             fault ? "an exception" : "a retirement", exp_pc);
                    order_errors++;
                end else if (fault) begin
                    check_exc(exc_code, exc_epc, exc_bd);
                end else begin
                    check_retire(retire_pc, retire_wen, retire_waddr, retire_wdata);
                end
                checked++;
            end
        end
        $display("%0d events checked: %0d value mismatches, %0d ordering errors, %0d timeouts",
                 checked, mismatch_count, order_errors, timeout_count);
        if (mismatch_count == 0 && order_errors == 0 && timeout_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
cpu_pkg.sv
pre_if_stage.sv
if_stage.sv
id_stage.sv
ex_stage.sv
wb_stage.sv
cpu_core.sv
tb_cpu_core.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - cpu_pkg.sv
  - pre_if_stage.sv
  - if_stage.sv
  - id_stage.sv
  - ex_stage.sv
  - wb_stage.sv
  - cpu_core.sv
  - target: simulation
    files:
      - tb_cpu_core.sv
